// File: src/snn_types_pkg.sv
// spiking neuron core, datapath types
// index widths, per-neuron state, potential write-back,
// spike events and the step controller states
package snn_types_pkg;

	localparam int NRN_AW = 4;
	localparam int AXN_AW = 4;
	localparam int DW = 16;
	localparam int SYN_AW = NRN_AW + AXN_AW;
	localparam int NUM_NRN = 1 << NRN_AW;
	localparam int NUM_AXN = 1 << AXN_AW;

	// weight memory address, neuron index in the upper bits
	typedef struct packed {
		logic [NRN_AW-1:0] nrn;
		logic [AXN_AW-1:0] axn;
	} syn_addr_t;

	typedef struct packed {
		logic [DW-1:0] bias;
		logic [DW-1:0] pot;
		logic [DW-1:0] thr;
	} nrn_state_t;

	typedef struct packed {
		logic valid;
		logic [NRN_AW-1:0] nrn;
		logic [DW-1:0] value;
	} pot_wr_t;

	typedef struct packed {
		logic valid;
		logic [NRN_AW-1:0] nrn;
	} spike_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_STATE,
		SCAN,
		FLUSH,
		WAIT_UPD
	} ctrl_state_e;

endpackage

// File: src/snn_host_pkg.sv
// spiking neuron core, host side types
// opcodes, host commands, memory writes and read-back
package snn_host_pkg;

	import snn_types_pkg::*;

	typedef enum logic [2:0] {
		WR_BIAS,
		WR_POT,
		WR_THR,
		WR_WEIGHT,
		SET_SPIKES,
		RD_POT,
		START
	} host_op_e;

	// neuron commands use the low address bits only
	typedef struct packed {
		logic valid;
		host_op_e op;
		logic [SYN_AW-1:0] addr;
		logic [DW-1:0] data;
	} host_cmd_t;

	typedef struct packed {
		logic valid;
		host_op_e op;
		logic [SYN_AW-1:0] addr;
		logic [DW-1:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic valid;
		logic [DW-1:0] data;
	} host_rd_t;

	typedef struct packed {
		logic valid;
		logic [NRN_AW-1:0] nrn;
	} rd_req_t;

endpackage

// File: src/weight_fifo.sv
// weight FIFO
// circular buffer between the weight memory and the accumulator,
// head word visible without a clock edge, clr_i empties it
module weight_fifo #(
	parameter int DW_P = 16,
	parameter int AW = 5
) (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            clr_i,
	input  logic [DW_P-1:0] din_i,
	input  logic            we_i,
	input  logic            re_i,
	output logic [DW_P-1:0] dout_o,
	output logic            empty_o
);

	localparam int DEPTH = 1 << AW;

	logic [DW_P-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_wr;
	logic do_rd;

	assign empty_o = (count == '0);
	assign do_wr = we_i && (count != (AW+1)'(DEPTH));
	assign do_rd = re_i && !empty_o;
	assign dout_o = mem[rd_ptr];

	always_ff @(posedge clk_i)
	begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/status_mem.sv
// neuron status memory
// bias, potential, threshold and weight memories with registered read
// addresses, potential write-port merge and the weight FIFO behind port W
module status_mem
	import snn_types_pkg::*;
	import snn_host_pkg::*;
#(
	parameter int WFIFO_AW = AXN_AW + 1
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              start_i,
	input  mem_wr_t           mem_wr_i,
	input  pot_wr_t           pot_wr_i,
	input  logic [NRN_AW-1:0] rd_a_addr_i,
	input  logic              rd_a_en_i,
	input  syn_addr_t         rd_w_addr_i,
	input  logic              rd_w_en_i,
	input  logic              fifo_pop_i,
	output nrn_state_t        state_o,
	output logic [DW-1:0]     fifo_data_o,
	output logic              fifo_nonempty_o
);

	logic [DW-1:0] bias_mem [NUM_NRN];
	logic [DW-1:0] pot_mem [NUM_NRN];
	logic [DW-1:0] thr_mem [NUM_NRN];
	logic [DW-1:0] w_mem [1 << SYN_AW];

	logic [NRN_AW-1:0] rd_a_addr_q;
	syn_addr_t rd_w_addr_q;
	logic [NRN_AW-1:0] host_nrn;
	logic pot_we;
	logic [NRN_AW-1:0] pot_waddr;
	logic [DW-1:0] pot_wdata;
	logic [DW-1:0] w_rdata;
	logic fifo_we;
	logic fifo_empty;

	assign host_nrn = mem_wr_i.addr[NRN_AW-1:0];

	// update write-back first, host writes only land while idle anyway
	always_comb
	begin
		if (pot_wr_i.valid)
		begin
			pot_we = 1'b1;
			pot_waddr = pot_wr_i.nrn;
			pot_wdata = pot_wr_i.value;
		end
		else
		begin
			pot_we = mem_wr_i.valid && (mem_wr_i.op == WR_POT);
			pot_waddr = host_nrn;
			pot_wdata = mem_wr_i.data;
		end
	end

	// port A, one address register shared by the three neuron memories
	always_ff @(posedge clk_i)
	begin
		if (rd_a_en_i)
			rd_a_addr_q <= rd_a_addr_i;
		if (mem_wr_i.valid && (mem_wr_i.op == WR_BIAS))
			bias_mem[host_nrn] <= mem_wr_i.data;
		if (mem_wr_i.valid && (mem_wr_i.op == WR_THR))
			thr_mem[host_nrn] <= mem_wr_i.data;
		if (pot_we)
			pot_mem[pot_waddr] <= pot_wdata;
	end

	assign state_o.bias = bias_mem[rd_a_addr_q];
	assign state_o.pot = pot_mem[rd_a_addr_q];
	assign state_o.thr = thr_mem[rd_a_addr_q];

	// weight port
	always_ff @(posedge clk_i)
	begin
		if (rd_w_en_i)
			rd_w_addr_q <= rd_w_addr_i;
		if (mem_wr_i.valid && (mem_wr_i.op == WR_WEIGHT))
			w_mem[mem_wr_i.addr] <= mem_wr_i.data;
	end

	assign w_rdata = w_mem[rd_w_addr_q];

	// read data settles one cycle after the enable, push it then
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			fifo_we <= 1'b0;
		else
			fifo_we <= rd_w_en_i;
	end

	weight_fifo #(
		.DW_P(DW),
		.AW(WFIFO_AW)
	) u_weight_fifo (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.clr_i(start_i),
		.din_i(w_rdata),
		.we_i(fifo_we),
		.re_i(fifo_pop_i),
		.dout_o(fifo_data_o),
		.empty_o(fifo_empty)
	);

	assign fifo_nonempty_o = !fifo_empty;

endmodule

// File: src/host_regs.sv
// host register block
// decodes host commands into memory writes, keeps the input spike
// vector and issues the start pulse and read-back requests
module host_regs
	import snn_types_pkg::*;
	import snn_host_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  host_cmd_t          host_cmd_i,
	input  logic               busy_i,
	output mem_wr_t            mem_wr_o,
	output logic [NUM_AXN-1:0] spikes_o,
	output logic               start_o,
	output rd_req_t            rd_req_o
);

	logic accept;
	logic is_write;

	// a start still in flight counts as busy
	assign accept = host_cmd_i.valid && !busy_i && !start_o;

	assign is_write = host_cmd_i.op inside {WR_BIAS, WR_POT, WR_THR, WR_WEIGHT};

	// writes go straight through, landing on the command edge
	assign mem_wr_o.valid = accept && is_write;
	assign mem_wr_o.op = host_cmd_i.op;
	assign mem_wr_o.addr = host_cmd_i.addr;
	assign mem_wr_o.data = host_cmd_i.data;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			spikes_o <= '0;
			start_o <= 1'b0;
			rd_req_o <= '0;
		end
		else
		begin
			start_o <= accept && (host_cmd_i.op == START);
			rd_req_o.valid <= accept && (host_cmd_i.op == RD_POT);
			rd_req_o.nrn <= host_cmd_i.addr[NRN_AW-1:0];
			// one bit per axon
			if (accept && (host_cmd_i.op == SET_SPIKES))
				spikes_o <= host_cmd_i.data[NUM_AXN-1:0];
		end
	end

endmodule

// File: src/step_ctrl.sv
// step controller
// walks all neurons in order, for each one reads its state, scans
// the axons and fetches weights of spiking axons, then waits for the update
module step_ctrl
	import snn_types_pkg::*;
	import snn_host_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               start_i,
	input  logic [NUM_AXN-1:0] spikes_i,
	input  rd_req_t            rd_req_i,
	input  logic               upd_done_i,
	output logic [NRN_AW-1:0]  rd_a_addr_o,
	output logic               rd_a_en_o,
	output syn_addr_t          rd_w_addr_o,
	output logic               rd_w_en_o,
	output logic               load_o,
	output logic               flush_o,
	output logic [NRN_AW-1:0]  nrn_o,
	output logic               busy_o,
	output logic               host_rd_valid_o,
	output logic               done_o
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic [NRN_AW-1:0] nrn_cnt;
	logic [AXN_AW-1:0] axn_cnt;
	logic last_nrn;

	assign last_nrn = (nrn_cnt == '1);

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (start_i)
					state_d = READ_STATE;
			READ_STATE:
				state_d = SCAN;
			SCAN:
				if (axn_cnt == '1)
					state_d = FLUSH;
			FLUSH:
				state_d = WAIT_UPD;
			WAIT_UPD:
				if (upd_done_i)
					state_d = last_nrn ? IDLE : READ_STATE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= IDLE;
			nrn_cnt <= '0;
			axn_cnt <= '0;
			done_o <= 1'b0;
			host_rd_valid_o <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// done coincides with the fall of busy
			done_o <= (state_q == WAIT_UPD) && upd_done_i && last_nrn;
			// port A data is settled one cycle after the forwarded request
			host_rd_valid_o <= (state_q == IDLE) && rd_req_i.valid;
			if (state_q == IDLE)
				nrn_cnt <= '0;
			else if ((state_q == WAIT_UPD) && upd_done_i)
				nrn_cnt <= nrn_cnt + 1'b1;
			if (state_q == SCAN)
				axn_cnt <= axn_cnt + 1'b1;
			else
				axn_cnt <= '0;
		end
	end

	// idle port A belongs to the host read-back
	assign rd_a_en_o = (state_q == READ_STATE) || ((state_q == IDLE) && rd_req_i.valid);
	assign rd_a_addr_o = (state_q == IDLE) ? rd_req_i.nrn : nrn_cnt;

	assign rd_w_en_o = (state_q == SCAN) && spikes_i[axn_cnt];
	assign rd_w_addr_o = '{nrn: nrn_cnt, axn: axn_cnt};

	// state data is valid in the first scan cycle
	assign load_o = (state_q == SCAN) && (axn_cnt == '0);
	assign flush_o = (state_q == FLUSH);
	assign nrn_o = nrn_cnt;
	assign busy_o = (state_q != IDLE);

endmodule

// File: src/neuron_update.sv
// neuron update stage
// accumulates bias, potential and fetched weights, then does the
// signed threshold compare, the potential write-back and the spike
module neuron_update
	import snn_types_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              load_i,
	input  logic              flush_i,
	input  logic [NRN_AW-1:0] nrn_i,
	input  nrn_state_t        state_i,
	input  logic [DW-1:0]     fifo_data_i,
	input  logic              fifo_nonempty_i,
	output logic              fifo_pop_o,
	output pot_wr_t           pot_wr_o,
	output spike_t            spike_o,
	output logic              upd_done_o
);

	logic [DW-1:0] acc_q;
	logic [DW-1:0] thr_q;
	logic [DW-1:0] val_q;
	logic [NRN_AW-1:0] nrn_q;
	logic pend_q;
	logic fin_q;
	logic spk_q;
	logic fire;
	logic finish;

	assign fifo_pop_o = fifo_nonempty_i;
	assign fire = ($signed(acc_q) >= $signed(thr_q));
	// last weight may still be in flight at flush, so wait for empty
	assign finish = pend_q && !fifo_nonempty_i;

	always_ff @(posedge clk_i)
	begin
		if (load_i)
		begin
			acc_q <= state_i.bias + state_i.pot;
			thr_q <= state_i.thr;
			nrn_q <= nrn_i;
		end
		else if (fifo_nonempty_i)
			acc_q <= acc_q + fifo_data_i;
		// fired neurons restart from zero
		if (finish)
			val_q <= fire ? '0 : acc_q;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pend_q <= 1'b0;
			fin_q <= 1'b0;
			spk_q <= 1'b0;
		end
		else
		begin
			fin_q <= finish;
			spk_q <= finish && fire;
			if (flush_i)
				pend_q <= 1'b1;
			else if (finish)
				pend_q <= 1'b0;
		end
	end

	assign pot_wr_o = '{valid: fin_q, nrn: nrn_q, value: val_q};
	assign spike_o = '{valid: spk_q, nrn: nrn_q};
	assign upd_done_o = fin_q;

endmodule

// File: src/neuron_core.sv
// spiking neuron core, top level
// host registers, step controller, status memory and update stage
module neuron_core
	import snn_types_pkg::*;
	import snn_host_pkg::*;
#(
	parameter int WFIFO_AW = AXN_AW + 1
) (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  host_cmd_t host_cmd_i,
	output logic      busy_o,
	output host_rd_t  host_rd_o,
	output spike_t    spike_o,
	output logic      done_o
);

	mem_wr_t mem_wr;
	logic [NUM_AXN-1:0] spikes;
	logic start;
	rd_req_t rd_req;
	logic [NRN_AW-1:0] rd_a_addr;
	logic rd_a_en;
	syn_addr_t rd_w_addr;
	logic rd_w_en;
	logic load;
	logic flush;
	logic [NRN_AW-1:0] nrn;
	logic host_rd_valid;
	logic upd_done;
	nrn_state_t nrn_state;
	logic [DW-1:0] fifo_data;
	logic fifo_nonempty;
	logic fifo_pop;
	pot_wr_t pot_wr;

	host_regs u_host_regs (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.host_cmd_i(host_cmd_i),
		.busy_i(busy_o),
		.mem_wr_o(mem_wr),
		.spikes_o(spikes),
		.start_o(start),
		.rd_req_o(rd_req)
	);

	step_ctrl u_step_ctrl (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.start_i(start),
		.spikes_i(spikes),
		.rd_req_i(rd_req),
		.upd_done_i(upd_done),
		.rd_a_addr_o(rd_a_addr),
		.rd_a_en_o(rd_a_en),
		.rd_w_addr_o(rd_w_addr),
		.rd_w_en_o(rd_w_en),
		.load_o(load),
		.flush_o(flush),
		.nrn_o(nrn),
		.busy_o(busy_o),
		.host_rd_valid_o(host_rd_valid),
		.done_o(done_o)
	);

	status_mem #(
		.WFIFO_AW(WFIFO_AW)
	) u_status_mem (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.start_i(start),
		.mem_wr_i(mem_wr),
		.pot_wr_i(pot_wr),
		.rd_a_addr_i(rd_a_addr),
		.rd_a_en_i(rd_a_en),
		.rd_w_addr_i(rd_w_addr),
		.rd_w_en_i(rd_w_en),
		.fifo_pop_i(fifo_pop),
		.state_o(nrn_state),
		.fifo_data_o(fifo_data),
		.fifo_nonempty_o(fifo_nonempty)
	);

	neuron_update u_neuron_update (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.load_i(load),
		.flush_i(flush),
		.nrn_i(nrn),
		.state_i(nrn_state),
		.fifo_data_i(fifo_data),
		.fifo_nonempty_i(fifo_nonempty),
		.fifo_pop_o(fifo_pop),
		.pot_wr_o(pot_wr),
		.spike_o(spike_o),
		.upd_done_o(upd_done)
	);

	// read-back data comes from the port A potential
	assign host_rd_o = '{valid: host_rd_valid, data: nrn_state.pot};

endmodule

// File: sim/tb_neuron_core.sv
// testbench for the spiking neuron core
// runs a table of host commands against a reference model of the
// neuron memories, checks read-back timing, spikes and step completion
module tb_neuron_core
	import snn_types_pkg::*;
	import snn_host_pkg::*;
;

	localparam int CLK_PERIOD = 100;
	localparam int STEP_CYCLES = NUM_AXN * 20 + 10;

	typedef struct packed {
		host_cmd_t cmd;
		logic in_step;
		logic [DW-1:0] exp_data;
	} tbl_entry_t;

	logic clk;
	logic rst_n;
	host_cmd_t host_cmd;
	logic busy;
	host_rd_t host_rd;
	spike_t spike;
	logic done;

	tbl_entry_t tbl[$];
	logic [NUM_NRN-1:0] exp_spk_q[$];

	// reference model of the core memories
	logic [DW-1:0] m_bias [NUM_NRN];
	logic [DW-1:0] m_pot [NUM_NRN];
	logic [DW-1:0] m_thr [NUM_NRN];
	logic [DW-1:0] m_w [1 << SYN_AW];
	logic [NUM_AXN-1:0] m_spk;

	logic [31:0] lfsr;
	logic table_ready;
	int steps_started;
	int steps_done;
	logic [NUM_NRN-1:0] spk_mask;
	logic [NRN_AW-1:0] last_spk;
	logic spk_seen;

	neuron_core #(
		.WFIFO_AW(AXN_AW + 1)
	) UUT (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.host_cmd_i(host_cmd),
		.busy_o(busy),
		.host_rd_o(host_rd),
		.spike_o(spike),
		.done_o(done)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [DW-1:0] rand_word(input int nbits);
		logic [DW-1:0] w;
		w = '0;
		for (int b = 0; b < nbits; b++)
			w = {w[DW-2:0], lfsr_bit()};
		return w;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s, got %0h expected %0h", $time, msg, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// one model step with wrapping adds and a signed compare
	task automatic model_step();
		logic [DW-1:0] sum;
		logic [NUM_NRN-1:0] mask;
		mask = '0;
		for (int n = 0; n < NUM_NRN; n++)
		begin
			sum = m_bias[n] + m_pot[n];
			for (int a = 0; a < NUM_AXN; a++)
			begin
				if (m_spk[a])
					sum = sum + m_w[n * NUM_AXN + a];
			end
			if ($signed(sum) >= $signed(m_thr[n]))
			begin
				mask[n] = 1'b1;
				m_pot[n] = '0;
			end
			else
				m_pot[n] = sum;
		end
		exp_spk_q.push_back(mask);
	endtask

	// commands sent during a step leave the model alone
	task automatic add_entry(input host_op_e op, input logic [SYN_AW-1:0] addr,
		input logic [DW-1:0] data, input logic in_step);
		tbl_entry_t e;
		e.cmd.valid = 1'b1;
		e.cmd.op = op;
		e.cmd.addr = addr;
		e.cmd.data = data;
		e.in_step = in_step;
		e.exp_data = '0;
		if (!in_step)
		begin
			case (op)
				WR_BIAS: m_bias[addr[NRN_AW-1:0]] = data;
				WR_POT: m_pot[addr[NRN_AW-1:0]] = data;
				WR_THR: m_thr[addr[NRN_AW-1:0]] = data;
				WR_WEIGHT: m_w[addr] = data;
				SET_SPIKES: m_spk = data[NUM_AXN-1:0];
				RD_POT: e.exp_data = m_pot[addr[NRN_AW-1:0]];
				START: model_step();
				default: ;
			endcase
		end
		tbl.push_back(e);
	endtask

	task automatic add_reads();
		for (int n = 0; n < NUM_NRN; n++)
			add_entry(RD_POT, SYN_AW'(n), '0, 1'b0);
	endtask

	task automatic build_table();
		for (int n = 0; n < NUM_NRN; n++)
		begin
			add_entry(WR_BIAS, SYN_AW'(n), rand_word(DW), 1'b0);
			add_entry(WR_POT, SYN_AW'(n), rand_word(DW), 1'b0);
			add_entry(WR_THR, SYN_AW'(n), rand_word(DW), 1'b0);
		end
		add_reads();
		for (int i = 0; i < (1 << SYN_AW); i++)
			add_entry(WR_WEIGHT, SYN_AW'(i), rand_word(DW), 1'b0);
		// first step without input spikes adds only the bias
		add_entry(SET_SPIKES, '0, '0, 1'b0);
		add_entry(START, '0, '0, 1'b0);
		add_reads();
		// chained steps with commands the core must drop while busy
		for (int s = 0; s < 3; s++)
		begin
			add_entry(SET_SPIKES, '0, rand_word(NUM_AXN), 1'b0);
			add_entry(START, '0, '0, 1'b0);
			// a neuron near the end, not yet updated when the write arrives
			add_entry(WR_POT, SYN_AW'(NUM_NRN - 1 - s), rand_word(DW), 1'b1);
			add_entry(WR_WEIGHT, SYN_AW'(rand_word(SYN_AW)), rand_word(DW), 1'b1);
			add_entry(SET_SPIKES, '0, rand_word(NUM_AXN), 1'b1);
			add_entry(START, '0, '0, 1'b1);
			add_reads();
		end
	endtask

	// busy is sampled between the drive edge and the command edge
	task automatic send_cmd(input host_cmd_t cmd, output logic busy_seen);
		@(posedge clk);
		host_cmd <= cmd;
		@(negedge clk);
		busy_seen = busy;
		@(posedge clk);
		host_cmd <= '0;
	endtask

	task automatic wait_busy();
		@(negedge clk);
		while (!busy)
			@(negedge clk);
	endtask

	task automatic wait_step_end();
		while (steps_done != steps_started)
			@(posedge clk);
	endtask

	task automatic check_readback(input logic [NRN_AW-1:0] nrn, input logic [DW-1:0] exp);
		@(negedge clk);
		check(32'(host_rd.valid), 32'd0, "read-back valid one cycle early");
		@(negedge clk);
		check(32'(host_rd.valid), 32'd1, "read-back valid missing two cycles after command");
		check(32'(host_rd.data), 32'(exp), $sformatf("potential of neuron %0d", nrn));
		@(negedge clk);
		check(32'(host_rd.valid), 32'd0, "read-back valid longer than one cycle");
	endtask

	// spike and done monitor
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (spike.valid)
			begin
				check(32'(busy), 32'd1, "spike event outside a step");
				if (spk_seen)
					check(32'(spike.nrn > last_spk), 32'd1, "spike events out of neuron order");
				spk_mask[spike.nrn] = 1'b1;
				last_spk = spike.nrn;
				spk_seen = 1'b1;
			end
			if (done)
			begin
				check(32'(busy), 32'd0, "busy_o still high with done_o");
				check(32'(steps_done < steps_started), 32'd1, "done_o with no step started");
				check(32'(spk_mask), 32'(exp_spk_q[steps_done]),
					$sformatf("spike set of step %0d", steps_done));
				steps_done++;
				spk_mask = '0;
				spk_seen = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		wait (table_ready);
		repeat (tbl.size() * STEP_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", tbl.size() * STEP_CYCLES);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin : main
		tbl_entry_t e;
		logic seen;
		rst_n = 1'b0;
		host_cmd = '0;
		table_ready = 1'b0;
		steps_started = 0;
		steps_done = 0;
		spk_mask = '0;
		last_spk = '0;
		spk_seen = 1'b0;
		lfsr = 32'h261c;
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check(32'(busy), 32'd0, "busy_o after reset");
		check(32'(done), 32'd0, "done_o after reset");
		check(32'(spike.valid), 32'd0, "spike valid after reset");
		check(32'(host_rd.valid), 32'd0, "read-back valid after reset");
		for (int i = 0; i < tbl.size(); i++)
		begin
			e = tbl[i];
			if (e.in_step)
			begin
				wait_busy();
				send_cmd(e.cmd, seen);
				check(32'(seen), 32'd1, "command meant for a running step met an idle core");
			end
			else
			begin
				wait_step_end();
				send_cmd(e.cmd, seen);
				check(32'(seen), 32'd0, "busy_o high before an idle command");
				if (e.cmd.op == RD_POT)
					check_readback(e.cmd.addr[NRN_AW-1:0], e.exp_data);
				if (e.cmd.op == START)
					steps_started++;
			end
		end
		wait_step_end();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: build.f
src/snn_types_pkg.sv
src/snn_host_pkg.sv
src/weight_fifo.sv
src/status_mem.sv
src/host_regs.sv
src/step_ctrl.sv
src/neuron_update.sv
src/neuron_core.sv
sim/tb_neuron_core.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_neuron_core
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
